// File: sim/controllerCases.txt
# rst opcode flags word, all hex, one line per clock cycle
# word: memAddr enPC saveOpcode saveMem aluFunc aluA aluB enA enB enC we wds saveResult enF sourceF inF re
1 0000 0 3048001
1 0000 0 3048001
1 0000 0 3048001
0 0272 0 3048001
0 0272 0 0194840
0 6A00 0 3048001
0 6A00 0 2848001
0 6A00 0 885E001
0 6A00 0 095A0C0
0 6A00 0 2048000
0 6A00 0 805E300
0 18D3 0 3048001
0 18D3 0 2848001
0 18D3 0 0CDA0C0
0 18D3 0 2048000
0 18D3 0 805E300
0 1F61 0 3048001
0 1F61 0 2848001
0 1F61 0 8850001
0 1F61 0 0D5A0C0
0 1F61 0 2048000
0 1F61 0 8050300
0 5905 0 3048001
0 5905 0 2848001
0 5905 0 46DA240
0 0CBB 0 3048001
0 0CBB 0 4800001
0 0CBB 0 02D6440
0 2E00 1 304806B
0 2800 F 304807D
0 2500 2 3048001
0 2500 2 204A000
0 2500 D 3048001
0 8123 0 3048001
0 8123 0 234C000
0 3000 0 3048001
0 3000 0 0000000
0 0272 0 0000000
0 2E00 1 0000000
1 0000 0 3048001
0 0272 0 3048001
0 0272 0 0194840
0 0000 0 3048001

// File: verilog.f
hw/cpuCtrlPkg.sv
hw/instrDecoder.sv
hw/ctrlSequencer.sv
hw/ctrlWordGen.sv
hw/cpuController.sv
sim/cpuControllerTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module cpuControllerTb \
    -Mdir "$buildDir" -f verilog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/VcpuControllerTb" > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi

if grep -q "Testbench failed" "$logFile"; then
    echo "Simulation reported failures, see $logFile"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: sim/cpuControllerTb.sv
module cpuControllerTb;
    import cpuCtrlPkg::*;

    localparam string CASE_FILE = "sim/controllerCases.txt";

    logic       clk;
    logic       rst;
    opcodeT     opcode;
    flagsT      flags;
    memAddrSrcT memAddr;
    logic       enPC;
    logic       saveOpcode;
    logic       saveMem;
    aluFuncT    aluFunc;
    aluSrcT     aluA;
    aluSrcT     aluB;
    logic       enA;
    logic       enB;
    logic       enC;
    logic       we;
    logic       writeDataSource;
    logic       saveResult;
    logic       enF;
    logic       sourceF;
    flagsT      inF;
    logic       re;

    logic        caseRst[$];
    opcodeT      caseOpcode[$];
    flagsT       caseFlags[$];
    logic [27:0] caseWord[$]; // Expected control word with memAddr in the top bits

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int cycleLimit = 20; // Raised once the cases are loaded

    cpuController cpuController_i (
        .clk(clk), .rst(rst), .opcode(opcode), .flags(flags),
        .memAddr(memAddr), .enPC(enPC), .saveOpcode(saveOpcode), .saveMem(saveMem),
        .aluFunc(aluFunc), .aluA(aluA), .aluB(aluB),
        .enA(enA), .enB(enB), .enC(enC), .we(we), .writeDataSource(writeDataSource),
        .saveResult(saveResult), .enF(enF), .sourceF(sourceF), .inF(inF), .re(re)
    );

    always #5 clk = ~clk;

    initial begin
        do begin
            @(posedge clk);
            cycles = cycles + 1;
        end while (cycles <= cycleLimit);
        $display("Timeout, the case list did not finish within %0d cycles", cycleLimit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

    function automatic string addrName(input memAddrSrcT src);
        string name;
        case (src)
            READ_FROM_PC: name = "PC";
            READ_FROM_A: name = "A";
            READ_FROM_ALU: name = "ALU";
            default: name = "unused";
        endcase
        return name;
    endfunction

    task automatic checkField(input string name, input logic [3:0] expVal,
                              input logic [3:0] actVal);
        checks++;
        assert (actVal == expVal) else begin
            errors++;
            $display("** Error at time %0t: %s expected %0h, actual %0h",
                     $time, name, expVal, actVal);
        end
    endtask

    task automatic checkWord(input logic [27:0] expWord);
        checks++;
        assert (memAddr == expWord[27:26]) else begin
            errors++;
            $display("** Error at time %0t: memAddr expected %0d (%s), actual %0d (%s)",
                     $time, expWord[27:26], addrName(expWord[27:26]), memAddr, addrName(memAddr));
        end
        checkField("enPC", 4'(expWord[25]), 4'(enPC));
        checkField("saveOpcode", 4'(expWord[24]), 4'(saveOpcode));
        checkField("saveMem", 4'(expWord[23]), 4'(saveMem));
        checkField("aluFunc", expWord[22:19], aluFunc);
        checkField("aluA", 4'(expWord[18:16]), 4'(aluA));
        checkField("aluB", 4'(expWord[15:13]), 4'(aluB));
        checkField("enA", 4'(expWord[12]), 4'(enA));
        checkField("enB", 4'(expWord[11]), 4'(enB));
        checkField("enC", 4'(expWord[10]), 4'(enC));
        checkField("we", 4'(expWord[9]), 4'(we));
        checkField("writeDataSource", 4'(expWord[8]), 4'(writeDataSource));
        checkField("saveResult", 4'(expWord[7]), 4'(saveResult));
        checkField("enF", 4'(expWord[6]), 4'(enF));
        checkField("sourceF", 4'(expWord[5]), 4'(sourceF));
        checkField("inF", expWord[4:1], inF);
        checkField("re", 4'(expWord[0]), 4'(re));
    endtask

    task automatic loadCases(output int fd);
        int          code;
        string       line;
        logic [31:0] rdRst;
        logic [31:0] rdOpcode;
        logic [31:0] rdFlags;
        logic [31:0] rdWord;
        fd = $fopen(CASE_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                // Comment lines and blank lines give fewer than four fields
                if (code > 0) begin
                    if ($sscanf(line, "%h %h %h %h", rdRst, rdOpcode, rdFlags, rdWord) == 4) begin
                        caseRst.push_back(rdRst[0]);
                        caseOpcode.push_back(rdOpcode[15:0]);
                        caseFlags.push_back(rdFlags[3:0]);
                        caseWord.push_back(rdWord[27:0]);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic runCases();
        int i;
        for (i = 0; i < caseWord.size(); i++) begin
            @(negedge clk);
            rst = caseRst[i];
            opcode = caseOpcode[i];
            flags = caseFlags[i];
            #4; // Sample one unit before the rising edge
            checkWord(caseWord[i]);
        end
    endtask

    initial begin
        int fd;
        clk = 1'b0;
        rst = 1'b1;
        opcode = '0;
        flags = '0;
        loadCases(fd);
        if (fd == 0 || caseWord.size() == 0) begin
            $display("Could not read any case from %s", CASE_FILE);
            $display("Testbench failed");
            $finish;
        end else begin
            cycleLimit = caseWord.size() + 20;
            runCases();
            @(negedge clk);
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

// File: hw/cpuController.sv
module cpuController (
    input  logic                   clk,
    input  logic                   rst,
    input  cpuCtrlPkg::opcodeT     opcode, // Current instruction
    input  cpuCtrlPkg::flagsT      flags, // Current flag register
    output cpuCtrlPkg::memAddrSrcT memAddr,
    output logic                   enPC,
    output logic                   saveOpcode,
    output logic                   saveMem,
    output cpuCtrlPkg::aluFuncT    aluFunc,
    output cpuCtrlPkg::aluSrcT     aluA,
    output cpuCtrlPkg::aluSrcT     aluB,
    output logic                   enA,
    output logic                   enB,
    output logic                   enC,
    output logic                   we,
    output logic                   writeDataSource,
    output logic                   saveResult,
    output logic                   enF,
    output logic                   sourceF,
    output cpuCtrlPkg::flagsT      inF,
    output logic                   re
);
    import cpuCtrlPkg::*;

    instrClassT instrClass;
    readModeT   readMode;
    writeModeT  writeMode;
    destSelT    destSel;
    aluSrcT     aluASrc;
    aluSrcT     aluBSrc;
    aluFuncT    opAluFunc; // ALU function field of the opcode
    logic       isFlagOp;
    flagsT      newFlags;
    stateT      state;

    instrDecoder instrDecoder_i (
        .opcode     (opcode),
        .flags      (flags),
        .instrClass (instrClass),
        .readMode   (readMode),
        .writeMode  (writeMode),
        .destSel    (destSel),
        .aluASrc    (aluASrc),
        .aluBSrc    (aluBSrc),
        .aluFunc    (opAluFunc),
        .isFlagOp   (isFlagOp),
        .newFlags   (newFlags)
    );

    ctrlSequencer ctrlSequencer_i (
        .clk        (clk),
        .rst        (rst),
        .instrClass (instrClass),
        .readMode   (readMode),
        .writeMode  (writeMode),
        .state      (state)
    );

    ctrlWordGen ctrlWordGen_i (
        .state           (state),
        .destSel         (destSel),
        .aluASrc         (aluASrc),
        .aluBSrc         (aluBSrc),
        .aluFunc         (opAluFunc),
        .isFlagOp        (isFlagOp),
        .newFlags        (newFlags),
        .memAddr         (memAddr),
        .enPC            (enPC),
        .saveOpcode      (saveOpcode),
        .saveMem         (saveMem),
        .aluFuncOut      (aluFunc),
        .aluA            (aluA),
        .aluB            (aluB),
        .enA             (enA),
        .enB             (enB),
        .enC             (enC),
        .we              (we),
        .writeDataSource (writeDataSource),
        .saveResult      (saveResult),
        .enF             (enF),
        .sourceF         (sourceF),
        .inF             (inF),
        .re              (re)
    );

    // Memory bus is half duplex, never read and write in one cycle
    noReadWrite: assert property (
        @(posedge clk) disable iff (rst)
        !(we && re)
    ) else $error("Memory read and write asserted together");

endmodule

// File: hw/ctrlWordGen.sv
module ctrlWordGen (
    input  cpuCtrlPkg::stateT      state,
    input  cpuCtrlPkg::destSelT    destSel,
    input  cpuCtrlPkg::aluSrcT     aluASrc, // Operand A of ALU instructions
    input  cpuCtrlPkg::aluSrcT     aluBSrc, // Operand B of ALU instructions
    input  cpuCtrlPkg::aluFuncT    aluFunc, // Function field from the opcode
    input  logic                   isFlagOp,
    input  cpuCtrlPkg::flagsT      newFlags,
    output cpuCtrlPkg::memAddrSrcT memAddr, // Source of memory address
    output logic                   enPC,
    output logic                   saveOpcode, // Load instruction register
    output logic                   saveMem, // Load memory value register
    output cpuCtrlPkg::aluFuncT    aluFuncOut,
    output cpuCtrlPkg::aluSrcT     aluA,
    output cpuCtrlPkg::aluSrcT     aluB,
    output logic                   enA,
    output logic                   enB,
    output logic                   enC,
    output logic                   we, // Memory write
    output logic                   writeDataSource,
    output logic                   saveResult, // Load result register
    output logic                   enF, // Flag register write
    output logic                   sourceF, // Flag input from inF
    output cpuCtrlPkg::flagsT      inF,
    output logic                   re // Memory read
);
    import cpuCtrlPkg::*;

    always_comb begin
        memAddr = READ_FROM_PC; // Idle value, zero
        enPC = 1'b0;
        saveOpcode = 1'b0;
        saveMem = 1'b0;
        aluFuncOut = ALU_ADD;
        aluA = 3'd0;
        aluB = 3'd0;
        enA = 1'b0;
        enB = 1'b0;
        enC = 1'b0;
        we = 1'b0;
        writeDataSource = WRITE_FROM_ALU;
        saveResult = 1'b0;
        enF = 1'b0;
        sourceF = 1'b0;
        inF = 4'd0;
        re = 1'b0;

        case (state)
            FETCH: begin
                memAddr = READ_FROM_PC; // Instruction at (PC)
                saveOpcode = 1'b1;
                re = 1'b1;
                aluA = ALU1_FROM_PC; // PC + 1
                aluB = ALU2_FROM_1;
                aluFuncOut = ALU_ADD;
                enPC = 1'b1;
                if (isFlagOp) begin
                    enF = 1'b1;
                    sourceF = 1'b1;
                    inF = newFlags;
                end
            end

            EXEC_A, EXEC_I, EXEC_SI: begin
                aluA = aluASrc;
                aluB = aluBSrc;
                aluFuncOut = aluFunc;
                enF = 1'b1;
                case (destSel)
                    DS_A: enA = 1'b1;
                    DS_B: enB = 1'b1;
                    DS_C: enC = 1'b1;
                    DS_ADR: begin
                        memAddr = READ_FROM_A; // Store to (A)
                        we = 1'b1;
                        writeDataSource = WRITE_FROM_ALU;
                    end
                    DS_DEFER: begin
                        // Keep the result, latch the address word at (PC)
                        saveResult = 1'b1;
                        memAddr = READ_FROM_PC;
                        saveMem = 1'b1;
                    end
                    default: ;
                endcase
            end

            EXEC_J: begin
                aluA = ALU1_FROM_PC;
                aluB = ALU2_FROM_ADDR; // Relative target
                aluFuncOut = ALU_JUMP;
                enPC = 1'b1;
            end

            JUMP_FLAG: begin
                aluA = ALU1_FROM_PC;
                aluB = ALU2_FROM_OP; // Offset from instruction
                aluFuncOut = ALU_ADD;
                enPC = 1'b1;
            end

            READ_IMM, READ_ABS1, READ_ABSI1: begin
                memAddr = READ_FROM_PC; // Operand word follows instruction
                saveMem = 1'b1;
                re = 1'b1;
                aluA = ALU1_FROM_PC;
                aluB = ALU2_FROM_1;
                aluFuncOut = ALU_ADD;
                enPC = 1'b1;
            end

            READ_ADDR: begin
                memAddr = READ_FROM_A;
                saveMem = 1'b1;
                re = 1'b1;
            end

            READ_ABS2, READ_ABSI2: begin
                memAddr = READ_FROM_ALU; // Address computed by ALU
                saveMem = 1'b1;
                re = 1'b1;
                aluA = ALU1_FROM_MEM;
                aluB = (state == READ_ABSI2) ? ALU2_FROM_A : ALU2_FROM_0;
                aluFuncOut = ALU_ADD;
            end

            WRITE_ABS1, WRITE_ABSI1: begin
                aluA = ALU1_FROM_PC; // Skip the address word
                aluB = ALU2_FROM_1;
                aluFuncOut = ALU_ADD;
                enPC = 1'b1;
            end

            WRITE_ABS2, WRITE_ABSI2: begin
                memAddr = READ_FROM_ALU;
                we = 1'b1;
                writeDataSource = WRITE_FROM_RES;
                aluA = ALU1_FROM_MEM;
                aluB = (state == WRITE_ABSI2) ? ALU2_FROM_A : ALU2_FROM_0;
                aluFuncOut = ALU_ADD;
            end

            default: ; // HALT drives nothing
        endcase
    end

endmodule

// File: hw/ctrlSequencer.sv
module ctrlSequencer (
    input  logic                   clk,
    input  logic                   rst,
    input  cpuCtrlPkg::instrClassT instrClass,
    input  cpuCtrlPkg::readModeT   readMode,
    input  cpuCtrlPkg::writeModeT  writeMode,
    output cpuCtrlPkg::stateT      state // Current FSM state
);
    import cpuCtrlPkg::*;

    stateT nextState;
    stateT execState; // Main state of the current instruction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        case (instrClass)
            CLS_A: execState = EXEC_A;
            CLS_I: execState = EXEC_I;
            CLS_SI: execState = EXEC_SI;
            default: execState = HALT; // Only ALU types pass through read states
        endcase
    end

    always_comb begin
        nextState = HALT;
        case (state)
            FETCH: begin
                case (instrClass)
                    CLS_A, CLS_I, CLS_SI: begin
                        case (readMode)
                            RD_IMM: nextState = READ_IMM;
                            RD_ADDR: nextState = READ_ADDR;
                            RD_ABS: nextState = READ_ABS1;
                            RD_ABSI: nextState = READ_ABSI1;
                            default: nextState = execState; // Register operand
                        endcase
                    end
                    CLS_J: nextState = EXEC_J;
                    CLS_JFG: nextState = JUMP_FLAG;
                    CLS_NOP: nextState = FETCH; // Flag op or jump not taken
                    default: nextState = HALT;
                endcase
            end

            READ_IMM, READ_ADDR, READ_ABS2, READ_ABSI2: begin
                nextState = execState;
            end
            READ_ABS1: nextState = READ_ABS2;
            READ_ABSI1: nextState = READ_ABSI2;

            EXEC_A, EXEC_I, EXEC_SI: begin
                case (writeMode)
                    WR_ABS: nextState = WRITE_ABS1;
                    WR_ABSI: nextState = WRITE_ABSI1;
                    default: nextState = FETCH;
                endcase
            end

            EXEC_J, JUMP_FLAG: nextState = FETCH;

            WRITE_ABS1: nextState = WRITE_ABS2;
            WRITE_ABSI1: nextState = WRITE_ABSI2;
            WRITE_ABS2, WRITE_ABSI2: nextState = FETCH;

            HALT: nextState = HALT; // Left only by reset
            default: nextState = HALT;
        endcase
    end

    // HALT is sticky until reset
    haltSticky: assert property (
        @(posedge clk) disable iff (rst)
        state == HALT |=> state == HALT
    ) else $error("Sequencer left HALT without reset");

endmodule

// File: hw/instrDecoder.sv
module instrDecoder (
    input  cpuCtrlPkg::opcodeT     opcode, // Current instruction
    input  cpuCtrlPkg::flagsT      flags, // Current flag register
    output cpuCtrlPkg::instrClassT instrClass,
    output cpuCtrlPkg::readModeT   readMode, // Addressing mode of source 1
    output cpuCtrlPkg::writeModeT  writeMode, // Deferred write-back mode
    output cpuCtrlPkg::destSelT    destSel,
    output cpuCtrlPkg::aluSrcT     aluASrc,
    output cpuCtrlPkg::aluSrcT     aluBSrc,
    output cpuCtrlPkg::aluFuncT    aluFunc, // ALU code taken from the opcode
    output logic                   isFlagOp, // FLS or FLC
    output cpuCtrlPkg::flagsT      newFlags // Flag value for FLS/FLC
);
    import cpuCtrlPkg::*;

    fieldT srcField;
    fieldT destField;
    flagsT flagMask;
    logic  flagCond;
    logic  isAlu;

    assign srcField = opcode[11:9]; // Source 1, same place in all ALU types
    assign flagMask = 4'b0001 << opcode[9:8];
    assign flagCond = (flags[opcode[9:8]] == opcode[10]);
    assign isFlagOp = (opcode[15:12] == 4'b0010) && opcode[11];
    assign newFlags = opcode[10] ? (flags | flagMask) : (flags & ~flagMask);

    always_comb begin
        if (opcode[15:12] == 4'b0000) begin
            instrClass = CLS_A;
        end else if (opcode[15:14] == 2'b01) begin
            instrClass = CLS_I;
        end else if (opcode[15]) begin
            instrClass = CLS_J;
        end else if (opcode[15:12] == 4'b0001) begin
            instrClass = CLS_SI;
        end else if (opcode[15:12] == 4'b0010) begin
            // Flag ops finish inside FETCH
            if (!opcode[11] && flagCond) begin
                instrClass = CLS_JFG;
            end else begin
                instrClass = CLS_NOP;
            end
        end else begin
            instrClass = CLS_ILLEGAL; // Includes the old stack opcodes
        end
    end

    assign isAlu = (instrClass == CLS_A) || (instrClass == CLS_I) || (instrClass == CLS_SI);

    always_comb begin
        readMode = RD_REG;
        if (isAlu && srcField[2]) begin
            case (srcField[1:0])
                2'b00: readMode = RD_IMM;
                2'b01: readMode = RD_ABS;
                2'b10: readMode = RD_ADDR;
                default: readMode = RD_ABSI;
            endcase
        end
    end

    assign aluASrc = (readMode == RD_REG) ? {1'b0, srcField[1:0]} : ALU1_FROM_MEM;

    always_comb begin
        case (instrClass)
            CLS_A: begin
                destField = opcode[2:0];
                aluFunc = opcode[8:5];
                aluBSrc = {1'b0, opcode[4:3]}; // Second register operand
            end
            CLS_I: begin
                destField = srcField; // Source doubles as destination
                aluFunc = {opcode[8], opcode[8], opcode[13:12]};
                aluBSrc = ALU2_FROM_OP;
            end
            CLS_SI: begin
                destField = opcode[6:4];
                aluFunc = {2'b10, opcode[8:7]}; // Shift group
                aluBSrc = ALU2_FROM_OP;
            end
            default: begin
                destField = DEST_NONE;
                aluFunc = ALU_ADD;
                aluBSrc = ALU2_FROM_0;
            end
        endcase
    end

    always_comb begin
        writeMode = WR_NONE;
        case (destField)
            DEST_A: destSel = DS_A;
            DEST_B: destSel = DS_B;
            DEST_C: destSel = DS_C;
            DEST_ADR: destSel = DS_ADR;
            DEST_ABS: begin
                destSel = DS_DEFER;
                writeMode = WR_ABS;
            end
            DEST_ABSI: begin
                destSel = DS_DEFER;
                writeMode = WR_ABSI;
            end
            default: destSel = DS_NONE; // DEST_NONE and the unused code
        endcase
    end

endmodule

// File: hw/cpuCtrlPkg.sv
package cpuCtrlPkg;

    typedef logic [15:0] opcodeT; // Instruction word
    typedef logic [3:0]  flagsT; // Flag register
    typedef logic [3:0]  aluFuncT; // ALU control code
    typedef logic [2:0]  aluSrcT; // ALU operand select, 0..3 are registers
    typedef logic [1:0]  memAddrSrcT; // Memory address select
    typedef logic [2:0]  fieldT; // Source or destination field

    // Memory address sources
    localparam memAddrSrcT READ_FROM_PC  = 2'd0;
    localparam memAddrSrcT READ_FROM_A   = 2'd1;
    localparam memAddrSrcT READ_FROM_ALU = 2'd2;

    localparam aluSrcT ALU1_FROM_PC  = 3'd4;
    localparam aluSrcT ALU1_FROM_MEM = 3'd5; // Internal memory value register

    localparam aluSrcT ALU2_FROM_1    = 3'd4;
    localparam aluSrcT ALU2_FROM_OP   = 3'd5; // Immediate from opcode
    localparam aluSrcT ALU2_FROM_ADDR = 3'd6; // Jump address from opcode
    localparam aluSrcT ALU2_FROM_0    = 3'd7;
    localparam aluSrcT ALU2_FROM_A    = 3'd0; // Index register

    localparam logic WRITE_FROM_ALU = 1'b0;
    localparam logic WRITE_FROM_RES = 1'b1; // Deferred result register

    localparam aluFuncT ALU_ADD  = 4'd0;
    localparam aluFuncT ALU_JUMP = 4'd6;

    // Destination field encoding
    localparam fieldT DEST_NONE = 3'd0;
    localparam fieldT DEST_A    = 3'd1;
    localparam fieldT DEST_B    = 3'd2;
    localparam fieldT DEST_C    = 3'd3;
    localparam fieldT DEST_ADR  = 3'd4; // Memory at (A)
    localparam fieldT DEST_ABS  = 3'd5;
    localparam fieldT DEST_ABSI = 3'd6;

    typedef enum logic [2:0] {
        CLS_A, CLS_I, CLS_SI, CLS_J, CLS_JFG, CLS_NOP, CLS_ILLEGAL
    } instrClassT;

    typedef enum logic [2:0] {
        RD_REG, RD_IMM, RD_ADDR, RD_ABS, RD_ABSI
    } readModeT;

    typedef enum logic [1:0] {
        WR_NONE, WR_ABS, WR_ABSI
    } writeModeT;

    typedef enum logic [2:0] {
        DS_NONE, DS_A, DS_B, DS_C, DS_ADR, DS_DEFER
    } destSelT;

    typedef enum logic [4:0] {
        FETCH,
        EXEC_A, EXEC_I, EXEC_SI, EXEC_J, JUMP_FLAG,
        READ_IMM, READ_ADDR,
        READ_ABS1, READ_ABS2, READ_ABSI1, READ_ABSI2,
        WRITE_ABS1, WRITE_ABS2, WRITE_ABSI1, WRITE_ABSI2,
        HALT
    } stateT;

endpackage
